// File: Bender.yml
package:
  name: s1c88_core

sources:
  - include_dirs:
      - source
    files:
      - source/s1c88_pkg.sv
      - source/fetch_unit.sv
      - source/micro_sequencer.sv
      - source/bus_interface.sv
      - source/s1c88_core.sv
  - target: simulation
    files:
      - verif/s1c88_core_tb.sv

// File: source/bus_interface.sv
`timescale 1ns/1ns

module bus_interface
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  addr_t       fetch_addr,
    input  logic        fetch_active,
    input  logic        opcode_cycle,
    input  logic        write_req,
    input  addr_t       write_addr,
    input  byte_t       write_data,
    output addr_t       address_out,
    output byte_t       data_out,
    output logic        read,
    output logic        write,
    output logic        sync,
    output bus_status_t bus_status,
    output logic        cycle_end
);

    // 0 in the first clock of a cycle, 1 in the second
    logic phase;

    assign cycle_end = phase;
    assign read      = phase && bus_status == BUS_MEM_READ;
    assign write     = phase && bus_status == BUS_MEM_WRITE;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            phase      <= 1'b0;
            bus_status <= BUS_IDLE;
            sync       <= 1'b0;
        end
        else
        begin
            phase <= ~phase;
            if (phase)
            begin
                // writes from the sequencer win over instruction fetch
                if (write_req)
                begin
                    bus_status <= BUS_MEM_WRITE;
                    sync       <= 1'b0;
                end
                else if (fetch_active)
                begin
                    bus_status <= BUS_MEM_READ;
                    sync       <= opcode_cycle;
                end
                else
                begin
                    bus_status <= BUS_IDLE;
                    sync       <= 1'b0;
                end
            end
        end
    end

    // address and data hold for the whole cycle
    always_ff @(posedge clk)
    begin
        if (phase)
        begin
            if (write_req)
            begin
                address_out <= write_addr;
                data_out    <= write_data;
            end
            else if (fetch_active)
                address_out <= fetch_addr;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(read && write));

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  byte_t       data_in,
    input  logic        cycle_end,
    input  logic        exec_done,
    output addr_t       fetch_addr,
    output logic        fetch_active,
    output logic        opcode_cycle,
    output ext_opcode_t ext_opcode,
    output word_t       imm,
    output logic        exec_start
);

    fetch_state_t state;
    fetch_state_t next_state;
    word_t        pc;
    word_t        prog_pc;
    logic [1:0]   wait_count;
    logic [1:0]   imm_bytes;
    logic [1:0]   lookahead_imm;
    ext_opcode_t  lookahead_op;
    logic         done_seen;

    // immediate bytes that follow each instruction
    function automatic logic [1:0] imm_count(ext_opcode_t op);
        case (op)
            {2'b00, OPCODE_LD_BR_IMM}:
                return 2'd1;
            {2'b00, OPCODE_LD_BR_IND_IMM}:
                return 2'd2;
            EXT_LD_EP_IMM:
                return 2'd1;
            default:
                return 2'd0;
        endcase
    endfunction

    // the byte on data_in is decoded in the clock it is sampled, so the
    // next read is already known when the bus starts its next cycle.
    // CE selects page 1 and CF page 2
    assign lookahead_op = (state == FETCH_OPEXT) ?
        {ext_opcode[0], ~ext_opcode[0], data_in} : {2'b00, data_in};
    assign lookahead_imm = imm_count(lookahead_op);

    // high byte of the vector is only in data_in on the last vector clock
    assign prog_pc = (state == FETCH_VECTOR_HIGH) ? {data_in, pc[7:0]} : pc;

    always_comb
    begin
        next_state = state;
        case (state)
            FETCH_RESET_WAIT:
                if (wait_count == 2'(RESET_WAIT_CYCLES - 1))
                    next_state = FETCH_VECTOR_LOW;
            FETCH_VECTOR_LOW:
                next_state = FETCH_VECTOR_HIGH;
            FETCH_VECTOR_HIGH:
                next_state = FETCH_OPCODE;
            FETCH_OPCODE:
                if (data_in == OPCODE_PREFIX_CE || data_in == OPCODE_PREFIX_CF)
                    next_state = FETCH_OPEXT;
                else if (lookahead_imm != 2'd0)
                    next_state = FETCH_IMM_LOW;
                else
                    next_state = FETCH_EXECUTE;
            FETCH_OPEXT:
                next_state = (lookahead_imm != 2'd0) ? FETCH_IMM_LOW : FETCH_EXECUTE;
            FETCH_IMM_LOW:
                next_state = (imm_bytes == 2'd2) ? FETCH_IMM_HIGH : FETCH_EXECUTE;
            FETCH_IMM_HIGH:
                next_state = FETCH_EXECUTE;
            FETCH_EXECUTE:
                if (done_seen)
                    next_state = FETCH_OPCODE;
            default:
                next_state = FETCH_RESET_WAIT;
        endcase
    end

    assign fetch_active = !(next_state inside {FETCH_RESET_WAIT, FETCH_EXECUTE});
    assign opcode_cycle = (next_state == FETCH_OPCODE);

    always_comb
    begin
        case (next_state)
            FETCH_VECTOR_LOW:
                fetch_addr = RESET_VECTOR_ADDR;
            FETCH_VECTOR_HIGH:
                fetch_addr = RESET_VECTOR_ADDR + 24'd1;
            default:
                fetch_addr = {8'h00, prog_pc};
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state      <= FETCH_RESET_WAIT;
            pc         <= '0;
            wait_count <= '0;
            imm_bytes  <= '0;
            exec_start <= 1'b0;
            done_seen  <= 1'b0;
        end
        else
        begin
            exec_start <= 1'b0;
            if (exec_done)
                done_seen <= 1'b1;

            // every transition lines up with a bus cycle boundary
            if (cycle_end)
            begin
                state <= next_state;
                if (state == FETCH_RESET_WAIT)
                    wait_count <= wait_count + 2'd1;
                if (state == FETCH_VECTOR_LOW)
                    pc[7:0] <= data_in;
                if (next_state inside {FETCH_OPCODE, FETCH_OPEXT, FETCH_IMM_LOW, FETCH_IMM_HIGH})
                    pc <= prog_pc + 16'd1;
                if (state inside {FETCH_OPCODE, FETCH_OPEXT})
                    imm_bytes <= lookahead_imm;
                if (next_state == FETCH_EXECUTE && state != FETCH_EXECUTE)
                    exec_start <= 1'b1;
                if (state == FETCH_EXECUTE && done_seen)
                    done_seen <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cycle_end)
        begin
            case (state)
                FETCH_OPCODE:
                    ext_opcode <= {2'b00, data_in};
                FETCH_OPEXT:
                    ext_opcode <= lookahead_op;
                FETCH_IMM_LOW:
                    imm[7:0] <= data_in;
                FETCH_IMM_HIGH:
                    imm[15:8] <= data_in;
                default:
                begin
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) exec_start |-> state == FETCH_EXECUTE);

    // the sequencer only finishes an instruction this unit handed over
    assert property (@(posedge clk) disable iff (reset)
        exec_done |-> state == FETCH_EXECUTE && !done_seen);

endmodule

// File: source/micro_sequencer.sv
`timescale 1ns/1ns

module micro_sequencer
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cycle_end,
    input  logic        exec_start,
    input  ext_opcode_t ext_opcode,
    input  word_t       imm,
    output logic        write_req,
    output addr_t       write_addr,
    output byte_t       write_data,
    output logic        exec_done
);

    `include "microcode_rom.svh"

    micro_addr_t micro_pc;
    microword_t  micro_op;
    micro_type_t micro_type;
    logic        micro_bus_op;
    logic        micro_done;
    micro_mov_t  micro_dst;
    micro_mov_t  micro_src;
    byte_t       src_byte;
    byte_t       ep;
    byte_t       br;
    logic        active;
    logic        write_pending;
    logic        step;

    assign micro_op     = microcode_word(micro_pc);
    assign micro_type   = micro_type_t'(micro_op[MW_TYPE_LSB +: $bits(micro_type_t)]);
    assign micro_bus_op = micro_op[MW_BUS_OP_BIT];
    assign micro_done   = micro_op[MW_DONE_BIT];
    assign micro_dst    = micro_mov_t'(micro_op[MW_DST_LSB +: $bits(micro_mov_t)]);
    assign micro_src    = micro_mov_t'(micro_op[MW_SRC_LSB +: $bits(micro_mov_t)]);

    always_comb
    begin
        case (micro_src)
            MICRO_MOV_IMM_LOW:
                src_byte = imm[7:0];
            MICRO_MOV_IMM_HIGH:
                src_byte = imm[15:8];
            MICRO_MOV_BR:
                src_byte = br;
            MICRO_MOV_EP:
                src_byte = ep;
            default:
                src_byte = '0;
        endcase
    end

    // request stays up until the bus takes it at a cycle boundary
    assign write_req = active && micro_type == MICRO_TYPE_BUS &&
                       micro_bus_op == MICRO_BUS_MEM_WRITE && !write_pending;
    assign write_addr = {ep, br, imm[7:0]};
    assign write_data = src_byte;

    // misc words take one clock, a bus word ends with its write cycle
    assign step = active && (micro_type != MICRO_TYPE_BUS || (cycle_end && write_pending));

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            micro_pc      <= '0;
            active        <= 1'b0;
            write_pending <= 1'b0;
            exec_done     <= 1'b0;
            ep            <= '0;
            br            <= '0;
        end
        else
        begin
            exec_done <= 1'b0;
            if (exec_start)
            begin
                micro_pc <= translate_opcode(ext_opcode);
                active   <= 1'b1;
            end
            else if (active)
            begin
                if (micro_type == MICRO_TYPE_MISC)
                begin
                    case (micro_dst)
                        MICRO_MOV_EP:
                            ep <= src_byte;
                        MICRO_MOV_BR:
                            br <= src_byte;
                        default:
                        begin
                        end
                    endcase
                end

                if (write_req && cycle_end)
                    write_pending <= 1'b1;

                if (step)
                begin
                    write_pending <= 1'b0;
                    if (micro_done)
                    begin
                        active    <= 1'b0;
                        exec_done <= 1'b1;
                    end
                    else
                        micro_pc <= micro_pc + 9'd1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        $rose(write_req) |-> active && !exec_done);

endmodule

// File: source/microcode_rom.svh
`ifndef MICROCODE_ROM_SVH
`define MICROCODE_ROM_SVH

// entry points into the microcode
localparam micro_addr_t UADDR_NOP          = 9'd0;
localparam micro_addr_t UADDR_LD_EP_IMM    = 9'd1;
localparam micro_addr_t UADDR_LD_BR_IMM    = 9'd2;
localparam micro_addr_t UADDR_LD_BR_IND    = 9'd3;

// extended opcode to first microword, anything unknown runs the nop
function automatic micro_addr_t translate_opcode(ext_opcode_t op);
    case (op)
        EXT_LD_EP_IMM:
            return UADDR_LD_EP_IMM;
        {2'b00, OPCODE_LD_BR_IMM}:
            return UADDR_LD_BR_IMM;
        {2'b00, OPCODE_LD_BR_IND_IMM}:
            return UADDR_LD_BR_IND;
        default:
            return UADDR_NOP;
    endcase
endfunction

function automatic microword_t microcode_word(micro_addr_t addr);
    case (addr)
        9'd0:
            return make_micro(MICRO_TYPE_MISC, MICRO_BUS_NONE, 1'b1, MICRO_MOV_NONE,
                              MICRO_MOV_NONE);
        9'd1:
            return make_micro(MICRO_TYPE_MISC, MICRO_BUS_NONE, 1'b1, MICRO_MOV_EP,
                              MICRO_MOV_IMM_LOW);
        9'd2:
            return make_micro(MICRO_TYPE_MISC, MICRO_BUS_NONE, 1'b1, MICRO_MOV_BR,
                              MICRO_MOV_IMM_LOW);
        // write of the high immediate to [BR:ll], then a closing step
        9'd3:
            return make_micro(MICRO_TYPE_BUS, MICRO_BUS_MEM_WRITE, 1'b0, MICRO_MOV_BR,
                              MICRO_MOV_IMM_HIGH);
        default:
            return make_micro(MICRO_TYPE_MISC, MICRO_BUS_NONE, 1'b1, MICRO_MOV_NONE,
                              MICRO_MOV_NONE);
    endcase
endfunction

`endif

// File: source/s1c88_core.sv
`timescale 1ns/1ns

module s1c88_core
    import s1c88_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  byte_t       data_in,
    output addr_t       address_out,
    output byte_t       data_out,
    output logic        read,
    output logic        write,
    output logic        sync,
    output bus_status_t bus_status
);

    logic        cycle_end;
    addr_t       fetch_addr;
    logic        fetch_active;
    logic        opcode_cycle;
    ext_opcode_t ext_opcode;
    word_t       imm;
    logic        exec_start;
    logic        exec_done;
    logic        write_req;
    addr_t       write_addr;
    byte_t       write_data;

    // instruction stream side
    fetch_unit fetch_i
    (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .cycle_end    (cycle_end),
        .exec_done    (exec_done),
        .fetch_addr   (fetch_addr),
        .fetch_active (fetch_active),
        .opcode_cycle (opcode_cycle),
        .ext_opcode   (ext_opcode),
        .imm          (imm),
        .exec_start   (exec_start)
    );

    micro_sequencer sequencer_i
    (
        .clk        (clk),
        .reset      (reset),
        .cycle_end  (cycle_end),
        .exec_start (exec_start),
        .ext_opcode (ext_opcode),
        .imm        (imm),
        .write_req  (write_req),
        .write_addr (write_addr),
        .write_data (write_data),
        .exec_done  (exec_done)
    );

    // external pins come from here
    bus_interface bus_i
    (
        .clk          (clk),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .fetch_active (fetch_active),
        .opcode_cycle (opcode_cycle),
        .write_req    (write_req),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .address_out  (address_out),
        .data_out     (data_out),
        .read         (read),
        .write        (write),
        .sync         (sync),
        .bus_status   (bus_status),
        .cycle_end    (cycle_end)
    );

endmodule

// File: source/s1c88_pkg.sv
package s1c88_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [23:0] addr_t;

    localparam int TRANSLATION_DEPTH = 768;
    localparam int MICROCODE_DEPTH   = 512;

    // two prefix page bits on top of the opcode byte
    typedef logic [$clog2(TRANSLATION_DEPTH)-1:0] ext_opcode_t;
    typedef logic [$clog2(MICROCODE_DEPTH)-1:0]   micro_addr_t;
    typedef logic [19:0]                          microword_t;

    typedef enum logic [1:0]
    {
        BUS_IDLE      = 2'd0,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_status_t;

    typedef enum logic [2:0]
    {
        FETCH_RESET_WAIT,
        FETCH_VECTOR_LOW,
        FETCH_VECTOR_HIGH,
        FETCH_OPCODE,
        FETCH_OPEXT,
        FETCH_IMM_LOW,
        FETCH_IMM_HIGH,
        FETCH_EXECUTE
    } fetch_state_t;

    typedef enum logic [2:0]
    {
        MICRO_TYPE_MISC = 3'd0,
        MICRO_TYPE_BUS  = 3'd1
    } micro_type_t;

    typedef enum logic [4:0]
    {
        MICRO_MOV_NONE     = 5'h00,
        MICRO_MOV_IMM_LOW  = 5'h02,
        MICRO_MOV_IMM_HIGH = 5'h03,
        MICRO_MOV_BR       = 5'h0D,
        MICRO_MOV_EP       = 5'h11
    } micro_mov_t;

    localparam byte_t       OPCODE_LD_BR_IMM     = 8'hB4;
    localparam byte_t       OPCODE_LD_BR_IND_IMM = 8'hDD;
    localparam byte_t       OPCODE_PREFIX_CE     = 8'hCE;
    localparam byte_t       OPCODE_PREFIX_CF     = 8'hCF;
    localparam ext_opcode_t EXT_LD_EP_IMM        = 10'h1C5;

    localparam addr_t RESET_VECTOR_ADDR = 24'h000000;
    localparam int    RESET_WAIT_CYCLES = 2;

    // microword layout, bits 16:13 and 11 are spare
    localparam int MW_TYPE_LSB   = 17;
    localparam int MW_BUS_OP_BIT = 12;
    localparam int MW_DONE_BIT   = 10;
    localparam int MW_DST_LSB    = 5;
    localparam int MW_SRC_LSB    = 0;

    localparam logic MICRO_BUS_NONE      = 1'b0;
    localparam logic MICRO_BUS_MEM_WRITE = 1'b1;

    function automatic microword_t make_micro(micro_type_t kind, logic bus_op, logic done,
                                              micro_mov_t dst, micro_mov_t src);
        microword_t mw;
        mw = '0;
        mw[MW_TYPE_LSB +: $bits(micro_type_t)] = kind;
        mw[MW_BUS_OP_BIT]                      = bus_op;
        mw[MW_DONE_BIT]                        = done;
        mw[MW_DST_LSB +: $bits(micro_mov_t)]   = dst;
        mw[MW_SRC_LSB +: $bits(micro_mov_t)]   = src;
        return mw;
    endfunction

endpackage

// File: tb.f
+incdir+source
source/s1c88_pkg.sv
source/fetch_unit.sv
source/micro_sequencer.sv
source/bus_interface.sv
source/s1c88_core.sv
verif/s1c88_core_tb.sv

// File: verif/s1c88_core_tb.sv
`timescale 1ns/1ns

module s1c88_core_tb
    import s1c88_pkg::*;
();

    localparam int NUM_ROWS       = 6;
    localparam int PROG_BYTES     = 12;
    localparam int MAX_WRITES     = 3;
    localparam int CYCLES_PER_ROW = 40;
    localparam int BUS_CYCLE_NS   = 8;

    logic        clk;
    logic        reset;
    byte_t       data_in;
    addr_t       address_out;
    byte_t       data_out;
    logic        read;
    logic        write;
    logic        sync;
    bus_status_t bus_status;

    // test table
    string row_name[NUM_ROWS];
    word_t row_vector[NUM_ROWS];
    byte_t row_prog[NUM_ROWS][PROG_BYTES];
    int    row_len[NUM_ROWS];
    int    row_instr[NUM_ROWS];
    int    row_writes[NUM_ROWS];
    addr_t row_waddr[NUM_ROWS][MAX_WRITES];
    byte_t row_wdata[NUM_ROWS][MAX_WRITES];
    int    row_count;

    int          cur_row;
    logic        monitor_on;
    int          read_idx;
    int          instr_idx;
    int          starts[$];
    addr_t       wr_addr_q[$];
    byte_t       wr_data_q[$];
    bus_status_t wr_status_q[$];
    logic [31:0] lfsr;
    int          checks_done;
    int          error_count;

    s1c88_core dut_i
    (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .address_out (address_out),
        .data_out    (data_out),
        .read        (read),
        .write       (write),
        .sync        (sync),
        .bus_status  (bus_status)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output byte_t b);
        for (int i = 0; i < 8; i++)
        begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // bytes an instruction occupies, prefix and extension included
    function automatic int instr_length(byte_t op, byte_t ext);
        case (op)
            8'hB4:
                return 2;
            8'hDD:
                return 3;
            8'hCE:
                return (ext == 8'hC5) ? 3 : 2;
            8'hCF:
                return 2;
            default:
                return 1;
        endcase
    endfunction

    function automatic byte_t fill_byte(addr_t a);
        return a[23:16] ^ a[15:8] ^ ~a[7:0];
    endfunction

    function automatic byte_t mem_byte(addr_t a);
        addr_t base;
        base = {8'h00, row_vector[cur_row]};
        if (a == RESET_VECTOR_ADDR)
            return row_vector[cur_row][7:0];
        if (a == RESET_VECTOR_ADDR + 24'd1)
            return row_vector[cur_row][15:8];
        if (a >= base && a < base + addr_t'(row_len[cur_row]))
            return row_prog[cur_row][a - base];
        return fill_byte(a);
    endfunction

    task automatic check_addr(string name, addr_t expected, addr_t actual);
        checks_done++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_byte(string name, byte_t expected, byte_t actual);
        checks_done++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(string name, bus_status_t expected, bus_status_t actual);
        checks_done++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %s expected %s actual %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        checks_done++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_int(string name, int expected, int actual);
        checks_done++;
        if (actual != expected)
        begin
            error_count++;
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // program bytes are right aligned in the vector, first byte highest
    task automatic add_row(string name, word_t vector, logic [95:0] bytes, int len, int n_instr);
        row_name[row_count]   = name;
        row_vector[row_count] = vector;
        row_len[row_count]    = len;
        row_instr[row_count]  = n_instr;
        row_writes[row_count] = 0;
        for (int i = 0; i < PROG_BYTES; i++)
            row_prog[row_count][i] = (i < len) ? bytes[8 * (len - 1 - i) +: 8] : 8'h00;
        row_count++;
    endtask

    task automatic add_write(addr_t a, byte_t d);
        row_waddr[row_count - 1][row_writes[row_count - 1]] = a;
        row_wdata[row_count - 1][row_writes[row_count - 1]] = d;
        row_writes[row_count - 1]++;
    endtask

    task automatic build_table();
        byte_t ep;
        byte_t br;
        byte_t l0;
        byte_t l1;
        byte_t l2;
        byte_t d0;
        byte_t d1;
        byte_t d2;
        row_count = 0;
        add_row("vector_nop", 16'h0120, {8'h00, 8'hFF, 8'h00}, 3, 3);
        add_row("ld_br_write", 16'h0340, {8'hB4, 8'h12, 8'hDD, 8'h34, 8'h56}, 5, 2);
        add_write(24'h001234, 8'h56);
        random_byte(ep);
        random_byte(br);
        random_byte(l0);
        random_byte(d0);
        add_row("ld_ep_write", 16'h1A00, {8'hCE, 8'hC5, ep, 8'hB4, br, 8'hDD, l0, d0}, 8, 3);
        add_write({ep, br, l0}, d0);
        // CF page and an unknown CE page entry are both two byte no-ops
        add_row("prefix_nop", 16'h0200,
            {8'hCF, 8'hC5, 8'hCE, 8'h20, 8'hB4, 8'h7E, 8'hDD, 8'h01, 8'h99}, 9, 4);
        add_write(24'h007E01, 8'h99);
        random_byte(br);
        random_byte(l0);
        random_byte(d0);
        random_byte(l1);
        random_byte(d1);
        random_byte(l2);
        random_byte(d2);
        add_row("three_writes", 16'h0480,
            {8'hB4, br, 8'hDD, l0, d0, 8'hDD, l1, d1, 8'h00, 8'hDD, l2, d2}, 12, 5);
        add_write({8'h00, br, l0}, d0);
        add_write({8'h00, br, l1}, d1);
        add_write({8'h00, br, l2}, d2);
        random_byte(ep);
        random_byte(br);
        random_byte(l0);
        random_byte(d0);
        random_byte(l1);
        random_byte(d1);
        add_row("ep_then_br", 16'h7F00,
            {8'hCE, 8'hC5, ep, 8'hDD, l0, d0, 8'hB4, br, 8'hDD, l1, d1}, 11, 4);
        add_write({ep, 8'h00, l0}, d0);
        add_write({ep, br, l1}, d1);
    endtask

    // memory answers reads from the current row's image
    always @(negedge clk)
    begin
        if (bus_status == BUS_MEM_READ)
            data_in <= mem_byte(address_out);
    end

    always @(negedge clk)
    begin : monitor
        int    off;
        logic  exp_sync;
        string name;
        name = row_name[cur_row];
        if (monitor_on && !reset)
        begin
            checks_done++;
            if (read && write)
            begin
                error_count++;
                $display("%s: read and write were both high in the same clock", name);
            end
            if (read)
            begin
                if (read_idx < 2)
                begin
                    check_addr({name, " vector read"}, RESET_VECTOR_ADDR + addr_t'(read_idx),
                               address_out);
                    check_flag({name, " vector sync"}, 1'b0, sync);
                end
                else
                begin
                    off = read_idx - 2;
                    check_addr({name, " program read"},
                               {8'h00, row_vector[cur_row] + word_t'(off)}, address_out);
                    exp_sync = instr_idx < starts.size() && off == starts[instr_idx];
                    check_flag({name, " sync"}, exp_sync, sync);
                    if (exp_sync)
                        instr_idx++;
                end
                read_idx++;
            end
            if (write)
            begin
                wr_addr_q.push_back(address_out);
                wr_data_q.push_back(data_out);
                wr_status_q.push_back(bus_status);
            end
        end
    end

    task automatic run_row(int r);
        int    off;
        byte_t ext;
        cur_row   = r;
        read_idx  = 0;
        instr_idx = 0;
        starts.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_status_q.delete();
        off = 0;
        for (int k = 0; k <= row_instr[r]; k++)
        begin
            starts.push_back(off);
            if (k < row_instr[r])
            begin
                ext = (off + 1 < PROG_BYTES) ? row_prog[r][off + 1] : 8'h00;
                off += instr_length(row_prog[r][off], ext);
            end
        end

        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        check_flag({row_name[r], " read in reset"}, 1'b0, read);
        check_flag({row_name[r], " write in reset"}, 1'b0, write);
        check_flag({row_name[r], " sync in reset"}, 1'b0, sync);
        check_flag({row_name[r], " exec_done in reset"}, 1'b0, dut_i.exec_done);
        check_status({row_name[r], " status in reset"}, BUS_IDLE, bus_status);
        reset = 1'b0;
        @(posedge clk);
        monitor_on = 1'b1;

        // run until the opcode after the last instruction is fetched
        while (instr_idx < starts.size())
            @(posedge clk);
        monitor_on = 1'b0;

        check_int({row_name[r], " write count"}, row_writes[r], wr_addr_q.size());
        for (int w = 0; w < row_writes[r] && w < wr_addr_q.size(); w++)
        begin
            check_addr({row_name[r], " write address"}, row_waddr[r][w], wr_addr_q[w]);
            check_byte({row_name[r], " write data"}, row_wdata[r][w], wr_data_q[w]);
            check_status({row_name[r], " write status"}, BUS_MEM_WRITE, wr_status_q[w]);
        end
    endtask

    initial
    begin
        #(NUM_ROWS * CYCLES_PER_ROW * BUS_CYCLE_NS);
        $display("timeout: the DUT did not finish the test rows in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        reset       = 1'b1;
        data_in     = 8'h00;
        monitor_on  = 1'b0;
        cur_row     = 0;
        read_idx    = 0;
        instr_idx   = 0;
        checks_done = 0;
        error_count = 0;
        lfsr        = 32'h98f7_51d8;
        build_table();
        for (int r = 0; r < row_count; r++)
            run_row(r);
        $display("rows: %0d, checks: %0d, errors: %0d", row_count, checks_done, error_count);
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
